// ==== config_register.sv ====
`timescale 1ns/100ps

module config_register #(
  parameter logic [7:0] REG_NUM     = 8'h00,
  parameter type        payload_t   = logic [7:0],
  parameter payload_t   RESET_VALUE = '0
) (
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  zxuno_pkg::reg_bus_t  reg_bus,
  output payload_t             value,
  output zxuno_pkg::rd_src_t   rd_src
);

  // Register number matches
  logic hit;

  // --------------------------------------------------
  // Payload must fill exactly one data byte
  // --------------------------------------------------

  if ($bits(payload_t) != 8) begin : g_bad_width
    $error("config_register payload is not 8 bits wide");
  end

  assign hit = (reg_bus.addr == REG_NUM);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Takes the byte at the end of the first write cycle
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      value <= RESET_VALUE;
    end else if (hit && reg_bus.wr_stb) begin
      value <= payload_t'(reg_bus.wdata);
    end
  end

  // Readback, no latency
  always_comb begin
    rd_src.data = 8'(value);
    rd_src.oe   = hit && reg_bus.rd;
  end

  // A held write must not store more than once
  a_single_wr_stb : assert property (
    @(posedge sysclk) disable iff (!rst_n) reg_bus.wr_stb |=> !reg_bus.wr_stb
  ) else $error("register %0h sees wr_stb longer than one cycle", REG_NUM);

endmodule

// ==== core_id_reader.sv ====
`timescale 1ns/100ps
`include "zxuno_params.svh"

module core_id_reader (
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  zxuno_pkg::reg_bus_t  reg_bus,
  output zxuno_pkg::rd_src_t   rd_src
);

  localparam int ID_LEN = `CORE_ID_LEN;
  // Index runs 0..ID_LEN, the last slot is the terminator
  localparam int IDX_W  = $clog2(ID_LEN + 1);

  // --------------------------------------------------
  // ID ROM
  // --------------------------------------------------

  // First char in the top byte, then a 0x00 terminator
  localparam logic [8*(ID_LEN+1)-1:0] ID_ROM = {`CORE_ID_STRING, 8'h00};

  logic             hit;
  logic [IDX_W-1:0] idx;
  logic [7:0]       id_char;

  assign hit = (reg_bus.addr == `REG_COREID);

  // Slot 0 sits in the top byte
  assign id_char = ID_ROM[8*(ID_LEN - int'(idx)) +: 8];

  // --------------------------------------------------
  // Character index
  // --------------------------------------------------

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (reg_bus.addr_changed) begin
      // Any new selection restarts the string
      idx <= '0;
    end else if (hit && reg_bus.rd_end) begin
      // Step once per finished read
      if (idx == IDX_W'(ID_LEN)) begin
        idx <= '0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // Read only, wr_stb to this number has no effect
  always_comb begin
    rd_src.data = id_char;
    rd_src.oe   = hit && reg_bus.rd;
  end

  // Index stays within the string plus terminator
  a_idx_range : assert property (
    @(posedge sysclk) disable iff (!rst_n) idx <= IDX_W'(ID_LEN)
  ) else $error("core ID index out of range: %0d", idx);

endmodule

// ==== cpu_data_mux.sv ====
`timescale 1ns/100ps
`include "zxuno_params.svh"

module cpu_data_mux #(
  parameter int N_SRC = 2
) (
  input  zxuno_pkg::cpu_bus_t  cpu,
  input  zxuno_pkg::rd_src_t   srcs [N_SRC],
  output logic [7:0]           cpu_din
);

  // Interrupt acknowledge cycle
  logic             intack;
  logic [N_SRC-1:0] oe_vec;

  assign intack = !cpu.iorq_n && !cpu.m1_n;

  // --------------------------------------------------
  // Priority select
  // --------------------------------------------------

  always_comb begin
    // Pulled-up bus by default
    cpu_din = `FLOAT_DATA;
    // Walk down so the lowest index wins
    for (int i = N_SRC - 1; i >= 0; i--) begin
      if (srcs[i].oe) begin
        cpu_din = srcs[i].data;
      end
    end
    // Acknowledge overrides every device
    if (intack) begin
      cpu_din = `INTACK_DATA;
    end
  end

  // Gather the enables for the bus check
  always_comb begin
    for (int i = 0; i < N_SRC; i++) begin
      oe_vec[i] = srcs[i].oe;
    end
  end

  // Devices decode disjoint ports and registers
  always_comb begin
    a_one_driver : assert ($onehot0(oe_vec))
      else $error("several read sources on the bus: %b", oe_vec);
  end

endmodule

// ==== list.f ====
+incdir+.
zxuno_pkg.sv
zxuno_addr_port.sv
config_register.sv
core_id_reader.sv
cpu_data_mux.sv
zxuno_core.sv
tb_zxuno.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_zxuno -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== tb_zxuno.sv ====
`timescale 1ns/100ps
`include "zxuno_params.svh"

module tb_zxuno;

  localparam int ACC_WR     = 0;
  localparam int ACC_RD     = 1;
  localparam int ACC_INTACK = 2;
  // Longest wait for an idle bus, in cycles
  localparam int IDLE_TIMEOUT = 50;
  localparam int ID_LEN = `CORE_ID_LEN;
  // First character in the top byte
  localparam logic [8*`CORE_ID_LEN-1:0] ID_STR = `CORE_ID_STRING;

  logic                sysclk;
  logic                rst_n;
  zxuno_pkg::cpu_bus_t cpu;
  logic [7:0]          cpu_din;
  zxuno_pkg::devopt_t  devopt;
  zxuno_pkg::scandbl_t scandbl;

  // Model state
  logic [7:0] model_addr;
  // devopt, scandbl, scratch, core ID (never written)
  logic [7:0] model_regs [4];
  int         model_idx;

  logic [31:0] rng = 32'hd676;
  int          checks;
  int          errors;

  zxuno_core UUT (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .cpu     (cpu),
    .cpu_din (cpu_din),
    .devopt  (devopt),
    .scandbl (scandbl)
  );

  initial begin
    sysclk = 1'b0;
    forever #4 sysclk = ~sysclk;
  end

  // --------------------------------------------------
  // Random numbers and model helpers
  // --------------------------------------------------

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // Access length of 1 to 3 cycles
  function automatic int rand_len();
    return int'(next_rand() % 32'd3) + 1;
  endfunction

  // Model slot of a register number, -1 when unmapped
  function automatic int reg_slot(input logic [7:0] r);
    case (r)
      `REG_DEVOPTIONS:  return 0;
      `REG_SCANDBLCTRL: return 1;
      `REG_SCRATCH:     return 2;
      `REG_COREID:      return 3;
      default:          return -1;
    endcase
  endfunction

  // Characters of the ID, then the 0x00 terminator
  function automatic logic [7:0] id_char(input int idx);
    if (idx >= ID_LEN) begin
      return 8'h00;
    end
    return ID_STR[8*(ID_LEN-1-idx) +: 8];
  endfunction

  // What the CPU should see when reading port a now
  function automatic logic [7:0] expected_read(input logic [15:0] a);
    int slot;
    slot = reg_slot(model_addr);
    if (a == `ZXUNO_ADDR_PORT) begin
      return model_addr;
    end
    if (a != `ZXUNO_DATA_PORT || slot < 0) begin
      return `FLOAT_DATA;
    end
    if (slot == 3) begin
      return id_char(model_idx);
    end
    return model_regs[slot];
  endfunction

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s returned %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Bus access tasks
  // --------------------------------------------------

  // Returns at the edge that ends an idle cycle
  task automatic wait_idle();
    int n;
    n = 0;
    @(posedge sysclk);
    while (!(cpu.iorq_n && cpu.rd_n && cpu.wr_n && cpu.m1_n)) begin
      n++;
      if (n >= IDLE_TIMEOUT) begin
        $display("Timeout: the CPU bus never went idle");
        $display("Testbench failed");
        $finish;
      end
      @(posedge sysclk);
    end
  endtask

  task automatic drive_idle();
    cpu.iorq_n <= 1'b1;
    cpu.rd_n   <= 1'b1;
    cpu.wr_n   <= 1'b1;
    cpu.m1_n   <= 1'b1;
  endtask

  task automatic run_access(input int kind, input logic [15:0] a, input logic [7:0] d,
                            input int len, output logic [7:0] q);
    int i;
    wait_idle();
    cpu.addr   <= a;
    cpu.wdata  <= d;
    cpu.iorq_n <= 1'b0;
    cpu.wr_n   <= (kind != ACC_WR);
    // Intack also pulls rd_n low, it has to beat a read
    cpu.rd_n   <= (kind == ACC_WR);
    cpu.m1_n   <= (kind != ACC_INTACK);
    q = 8'h00;
    // Sample mid-cycle, last cycle wins
    for (i = 0; i < len; i++) begin
      @(negedge sysclk);
      q = cpu_din;
      @(posedge sysclk);
    end
    drive_idle();
  endtask

  task automatic io_write(input logic [15:0] a, input logic [7:0] d, input int len);
    logic [7:0] unused;
    int         slot;
    run_access(ACC_WR, a, d, len, unused);
    slot = reg_slot(model_addr);
    if (a == `ZXUNO_ADDR_PORT) begin
      model_addr = d;
      model_idx  = 0;
    end else if (a == `ZXUNO_DATA_PORT && slot >= 0 && slot < 3) begin
      model_regs[slot] = d;
    end
  endtask

  task automatic io_read(input logic [15:0] a, input int len, output logic [7:0] q);
    run_access(ACC_RD, a, 8'h00, len, q);
    // ID index steps once per finished read, wrapping after the terminator
    if (a == `ZXUNO_DATA_PORT && model_addr == `REG_COREID) begin
      model_idx = (model_idx >= ID_LEN) ? 0 : model_idx + 1;
    end
  endtask

  // Read with the model's expectation taken before the access
  task automatic read_check(input string what, input logic [15:0] a, input int len);
    logic [7:0] exp;
    logic [7:0] got;
    exp = expected_read(a);
    io_read(a, len, got);
    check_byte(what, got, exp);
  endtask

  task automatic check_outputs();
    @(negedge sysclk);
    check_byte("devopt port", devopt, model_regs[0]);
    check_byte("scandbl port", scandbl, model_regs[1]);
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  initial begin
    int         i;
    int         base;
    int         pick;
    logic [7:0] r;
    logic [7:0] d;
    logic [7:0] got;
    logic [15:0] a;

    checks        = 0;
    errors        = 0;
    model_addr    = 8'h00;
    model_idx     = 0;
    model_regs[0] = `DEVOPT_RESET;
    model_regs[1] = `SCANDBL_RESET;
    model_regs[2] = `SCRATCH_RESET;
    model_regs[3] = 8'h00;
    cpu.addr      = 16'h0000;
    cpu.wdata     = 8'h00;
    cpu.iorq_n    = 1'b1;
    cpu.rd_n      = 1'b1;
    cpu.wr_n      = 1'b1;
    cpu.m1_n      = 1'b1;
    rst_n         = 1'b0;
    repeat (2) @(posedge sysclk);
    rst_n <= 1'b1;

    // Reset values
    base = errors;
    @(negedge sysclk);
    check_byte("devopt after reset", devopt, `DEVOPT_RESET);
    check_byte("scandbl after reset", scandbl, `SCANDBL_RESET);
    io_write(`ZXUNO_ADDR_PORT, `REG_SCRATCH, 1);
    io_read(`ZXUNO_DATA_PORT, 1, got);
    check_byte("scratch after reset", got, `SCRATCH_RESET);
    report_test("test 1 reset values", base);

    // Address port write and readback
    base = errors;
    for (i = 0; i < 200; i++) begin
      d = 8'(next_rand());
      io_write(`ZXUNO_ADDR_PORT, d, rand_len());
      read_check("address port", `ZXUNO_ADDR_PORT, rand_len());
    end
    report_test("test 2 address port", base);

    // Writable registers, plus writes to other numbers
    base = errors;
    for (i = 0; i < 300; i++) begin
      pick = int'(next_rand() % 32'd4);
      case (pick)
        0:       r = `REG_DEVOPTIONS;
        1:       r = `REG_SCANDBLCTRL;
        2:       r = `REG_SCRATCH;
        default: r = 8'(next_rand());
      endcase
      // Keep the "other" pick off the writable numbers
      if (pick == 3 && reg_slot(r) >= 0 && reg_slot(r) < 3) begin
        r = r ^ 8'h10;
      end
      d = 8'(next_rand());
      io_write(`ZXUNO_ADDR_PORT, r, rand_len());
      io_write(`ZXUNO_DATA_PORT, d, rand_len());
      check_outputs();
      read_check("data port readback", `ZXUNO_DATA_PORT, rand_len());
    end
    report_test("test 3 register access", base);

    // Core ID string, terminator and wrap
    base = errors;
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID, 1);
    for (i = 0; i < 20; i++) begin
      read_check("core ID", `ZXUNO_DATA_PORT, rand_len());
    end
    for (i = 0; i < 3; i++) begin
      read_check("core ID", `ZXUNO_DATA_PORT, 1);
    end
    // Reselect mid-string, must restart
    io_write(`ZXUNO_ADDR_PORT, `REG_COREID, rand_len());
    io_read(`ZXUNO_DATA_PORT, 1, got);
    check_byte("core ID after reselect", got, id_char(0));
    report_test("test 4 core ID", base);

    // Interrupt acknowledge and unmapped ports
    base = errors;
    io_write(`ZXUNO_ADDR_PORT, `REG_SCRATCH, 1);
    // Scratch holds a byte that differs from the acknowledge value
    io_write(`ZXUNO_DATA_PORT, 8'h5A, 1);
    for (i = 0; i < 10; i++) begin
      run_access(ACC_INTACK, `ZXUNO_DATA_PORT, 8'h00, rand_len(), got);
      check_byte("interrupt acknowledge", got, `INTACK_DATA);
    end
    for (i = 0; i < 50; i++) begin
      a = 16'(next_rand());
      // Step off the two decoded ports
      if (a == `ZXUNO_ADDR_PORT || a == `ZXUNO_DATA_PORT) begin
        a = a ^ 16'h0001;
      end
      read_check("unmapped port", a, rand_len());
    end
    report_test("test 5 bus defaults", base);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== zxuno_addr_port.sv ====
`timescale 1ns/100ps
`include "zxuno_params.svh"

module zxuno_addr_port (
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  zxuno_pkg::cpu_bus_t  cpu,
  output zxuno_pkg::reg_bus_t  reg_bus,
  output zxuno_pkg::rd_src_t   addr_rd
);

  // Decoded accesses
  logic       io_cycle;
  logic       sel_addr;
  logic       sel_data;
  logic       wr_addr;
  logic       rd_addr;
  logic       wr_data;
  logic       rd_data;
  // Strobes one cycle late, for edge detection
  logic       wr_addr_q;
  logic       wr_data_q;
  logic       rd_data_q;
  logic       addr_first;
  logic [7:0] reg_addr;
  logic       addr_changed;

  // --------------------------------------------------
  // Port decode
  // --------------------------------------------------

  // Intack also has iorq_n low, keep it out
  assign io_cycle = !cpu.iorq_n && cpu.m1_n;
  assign sel_addr = io_cycle && (cpu.addr == `ZXUNO_ADDR_PORT);
  assign sel_data = io_cycle && (cpu.addr == `ZXUNO_DATA_PORT);

  assign wr_addr = sel_addr && !cpu.wr_n;
  assign rd_addr = sel_addr && !cpu.rd_n;
  assign wr_data = sel_data && !cpu.wr_n;
  assign rd_data = sel_data && !cpu.rd_n;

  // Only the first cycle of a long write counts
  assign addr_first = wr_addr && !wr_addr_q;

  // --------------------------------------------------
  // Address latch and pulse generation
  // --------------------------------------------------

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr_q    <= 1'b0;
      wr_data_q    <= 1'b0;
      rd_data_q    <= 1'b0;
      reg_addr     <= 8'h00;
      addr_changed <= 1'b0;
    end else begin
      wr_addr_q    <= wr_addr;
      wr_data_q    <= wr_data;
      rd_data_q    <= rd_data;
      // Lands one cycle after the latch
      addr_changed <= addr_first;
      if (addr_first) begin
        reg_addr <= cpu.wdata;
      end
    end
  end

  always_comb begin
    reg_bus.addr         = reg_addr;
    reg_bus.rd           = rd_data;
    reg_bus.wr_stb       = wr_data && !wr_data_q;
    // Falling edge of the read level
    reg_bus.rd_end       = rd_data_q && !rd_data;
    reg_bus.addr_changed = addr_changed;
    reg_bus.wdata        = cpu.wdata;
  end

  // Address port reads back the latched number
  always_comb begin
    addr_rd.data = reg_addr;
    addr_rd.oe   = rd_addr;
  end

  // A register never sees a write and a read in the same cycle
  a_no_wr_during_rd : assert property (
    @(posedge sysclk) disable iff (!rst_n) !(reg_bus.wr_stb && reg_bus.rd)
  ) else $error("wr_stb and rd high together");

endmodule

// ==== zxuno_core.sv ====
`timescale 1ns/100ps
`include "zxuno_params.svh"

module zxuno_core (
  input  logic                 sysclk,
  input  logic                 rst_n,
  input  zxuno_pkg::cpu_bus_t  cpu,
  output logic [7:0]           cpu_din,
  output zxuno_pkg::devopt_t   devopt,
  output zxuno_pkg::scandbl_t  scandbl
);

  // --------------------------------------------------
  // Read source slots, lower index wins in the mux
  // --------------------------------------------------

  localparam int SRC_ADDR    = 0;
  localparam int SRC_COREID  = 1;
  localparam int SRC_DEVOPT  = 2;
  localparam int SRC_SCANDBL = 3;
  localparam int SRC_SCRATCH = 4;
  localparam int N_SRC       = 5;

  // Register bus from the address port
  zxuno_pkg::reg_bus_t reg_bus;
  // Per-device read data and enables
  zxuno_pkg::rd_src_t  srcs [N_SRC];

  // Address latch and strobe generator
  zxuno_addr_port u_addr_port (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .cpu     (cpu),
    .reg_bus (reg_bus),
    .addr_rd (srcs[SRC_ADDR])
  );

  // Core ID text, read only
  core_id_reader u_core_id (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .reg_bus (reg_bus),
    .rd_src  (srcs[SRC_COREID])
  );

  // --------------------------------------------------
  // Writable configuration registers
  // --------------------------------------------------

  config_register #(
    .REG_NUM     (`REG_DEVOPTIONS),
    .payload_t   (zxuno_pkg::devopt_t),
    .RESET_VALUE (zxuno_pkg::devopt_t'(`DEVOPT_RESET))
  ) u_devopt (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .reg_bus (reg_bus),
    .value   (devopt),
    .rd_src  (srcs[SRC_DEVOPT])
  );

  // cpu_speed only leaves as a port here
  config_register #(
    .REG_NUM     (`REG_SCANDBLCTRL),
    .payload_t   (zxuno_pkg::scandbl_t),
    .RESET_VALUE (zxuno_pkg::scandbl_t'(`SCANDBL_RESET))
  ) u_scandbl (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .reg_bus (reg_bus),
    .value   (scandbl),
    .rd_src  (srcs[SRC_SCANDBL])
  );

  // Scratch byte, only visible through the data port
  config_register #(
    .REG_NUM     (`REG_SCRATCH),
    .payload_t   (logic [7:0]),
    .RESET_VALUE (`SCRATCH_RESET)
  ) u_scratch (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .reg_bus (reg_bus),
    .value   (),
    .rd_src  (srcs[SRC_SCRATCH])
  );

  // Byte back to the CPU
  cpu_data_mux #(
    .N_SRC (N_SRC)
  ) u_data_mux (
    .cpu     (cpu),
    .srcs    (srcs),
    .cpu_din (cpu_din)
  );

endmodule

// ==== zxuno_params.svh ====
`ifndef ZXUNO_PARAMS_SVH
`define ZXUNO_PARAMS_SVH

// --------------------------------------------------
// I/O ports of the register bank
// --------------------------------------------------

// Register number port, decoded on all 16 bits
`define ZXUNO_ADDR_PORT 16'hFC3B
// Data port for the selected register
`define ZXUNO_DATA_PORT 16'hFD3B

// --------------------------------------------------
// Register numbers
// --------------------------------------------------

// Video output and CPU speed
`define REG_SCANDBLCTRL 8'h0B
// Peripheral disable flags
`define REG_DEVOPTIONS  8'h0E
// Free byte for software use
`define REG_SCRATCH     8'hFE
// Core identification text
`define REG_COREID      8'hFF

// Power-up contents
`define SCANDBL_RESET   8'h01
`define DEVOPT_RESET    8'h00
`define SCRATCH_RESET   8'h00

// --------------------------------------------------
// Core ID and bus defaults
// --------------------------------------------------

// Returned one char per data port read
`define CORE_ID_STRING  "EXP-0102"
`define CORE_ID_LEN     8

// Byte seen by the CPU during an interrupt acknowledge
`define INTACK_DATA     8'hFF
// Pulled-up bus when nobody drives it
`define FLOAT_DATA      8'hFF

`endif

// ==== zxuno_pkg.sv ====
package zxuno_pkg;

  // --------------------------------------------------
  // CPU side
  // --------------------------------------------------

  // Z80 I/O bus as seen at the core boundary
  typedef struct packed {
    logic [15:0] addr;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic [7:0]  wdata;
  } cpu_bus_t;

  // --------------------------------------------------
  // Internal register bus
  // --------------------------------------------------

  // Fanned out from the address port to every register
  typedef struct packed {
    logic [7:0] addr;
    // Level, whole data port read
    logic       rd;
    // Pulse, first cycle of data port write
    logic       wr_stb;
    // Pulse, cycle after data port read
    logic       rd_end;
    // Pulse, cycle after address port write
    logic       addr_changed;
    logic [7:0] wdata;
  } reg_bus_t;

  // One read source toward the CPU data mux
  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } rd_src_t;

  // --------------------------------------------------
  // Register payloads
  // --------------------------------------------------

  // Device enable options, bit 7 first
  typedef struct packed {
    logic disable_mixer;
    logic disable_specdrum;
    logic disable_ulaplus;
    logic disable_timexscr;
    logic disable_spisd;
    logic disable_turboay;
    logic disable_7ffd;
    logic disable_ay;
  } devopt_t;

  // Scan doubler and speed control
  typedef struct packed {
    logic [1:0] cpu_speed;
    logic       csync_option;
    logic [2:0] freq_option;
    logic       scanlines_enable;
    logic       vga_enable;
  } scandbl_t;

endpackage
